//--- exu.f
logic/exu_op_pkg.sv
logic/exu_data_pkg.sv
logic/exu_issue_reg.sv
logic/exu_alu.sv
logic/exu_branch_unit.sv
logic/exu_csr_write.sv
logic/exu_top.sv
verification/exu_assert.sv
verification/exu_tb.sv

//--- logic/exu_alu.sv
`timescale 1ns/10ps
`default_nettype none

module exu_alu (
    input  exu_data_pkg::ex_issue_t ex_issue,
    output exu_data_pkg::xlen_t     alu_result
);
    import exu_op_pkg::*;
    import exu_data_pkg::*;

    typedef enum logic [3:0] {
        ALU_ZERO,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_mode_e;

    alu_mode_e  mode;
    xlen_t      op_a;
    xlen_t      op_b;
    xlen_t      a_eff;
    xlen_t      raw;
    logic       is_word;
    logic [5:0] shamt;

    // operand a
    always_comb begin
        case (ex_issue.op)
            OP_AUIPC, OP_JAL, OP_JALR: op_a = ex_issue.pc;
            OP_LUI:                    op_a = '0;
            default:                   op_a = ex_issue.src_a;
        endcase
    end

    // operand b, jumps add the step to get the link address
    always_comb begin
        case (ex_issue.op)
            OP_ADDI, OP_ANDI, OP_ORI, OP_XORI,
            OP_SLLI, OP_SRLI, OP_SRAI,
            OP_LUI, OP_AUIPC:          op_b = ex_issue.imm;
            OP_JAL, OP_JALR:           op_b = xlen_t'(INST_BYTES);
            default:                   op_b = ex_issue.src_b;
        endcase
    end

    // opcode to alu mode
    always_comb begin
        case (ex_issue.op)
            OP_ADD, OP_ADDI, OP_ADDW,
            OP_LUI, OP_AUIPC, OP_JAL, OP_JALR: mode = ALU_ADD;
            // branches leave a - b on the result bus
            OP_SUB, OP_SUBW,
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE,
            OP_BLTU, OP_BGEU:                  mode = ALU_SUB;
            OP_AND, OP_ANDI:                   mode = ALU_AND;
            OP_OR, OP_ORI:                     mode = ALU_OR;
            OP_XOR, OP_XORI:                   mode = ALU_XOR;
            OP_SLT:                            mode = ALU_SLT;
            OP_SLTU:                           mode = ALU_SLTU;
            OP_SLL, OP_SLLI, OP_SLLW:          mode = ALU_SLL;
            OP_SRL, OP_SRLI, OP_SRLW:          mode = ALU_SRL;
            OP_SRA, OP_SRAI, OP_SRAW:          mode = ALU_SRA;
            // csr, ecall, mret, nop
            default:                           mode = ALU_ZERO;
        endcase
    end

    assign is_word = ex_issue.op inside {OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW};

    // word right shifts need the upper half filled from bit 31 or zero
    assign a_eff = is_word ? {{32{(mode == ALU_SRA) & op_a[31]}}, op_a[31:0]} : op_a;
    assign shamt = is_word ? {1'b0, op_b[4:0]} : op_b[5:0];

    always_comb begin
        case (mode)
            ALU_ADD:  raw = a_eff + op_b;
            ALU_SUB:  raw = a_eff - op_b;
            ALU_AND:  raw = a_eff & op_b;
            ALU_OR:   raw = a_eff | op_b;
            ALU_XOR:  raw = a_eff ^ op_b;
            ALU_SLT:  raw = xlen_t'($signed(a_eff) < $signed(op_b));
            ALU_SLTU: raw = xlen_t'(a_eff < op_b);
            ALU_SLL:  raw = a_eff << shamt;
            ALU_SRL:  raw = a_eff >> shamt;
            ALU_SRA:  raw = xlen_t'($signed(a_eff) >>> shamt);
            default:  raw = '0;
        endcase
    end

    // word results sign-extend bit 31
    assign alu_result = is_word ? {{32{raw[31]}}, raw[31:0]} : raw;

endmodule

`default_nettype wire

//--- logic/exu_branch_unit.sv
`timescale 1ns/10ps
`default_nettype none

module exu_branch_unit (
    input  exu_data_pkg::ex_issue_t ex_issue,
    output exu_data_pkg::xlen_t     dnpc,
    output logic                    pc_update
);
    import exu_op_pkg::*;
    import exu_data_pkg::*;

    xlen_t b_off;
    xlen_t snpc;
    xlen_t jalr_sum;
    logic  eq;
    logic  lt;
    logic  ltu;
    logic  taken;

    // b-type offset, bit 0 always zero
    assign b_off = {{51{ex_issue.inst[31]}}, ex_issue.inst[31], ex_issue.inst[7],
                    ex_issue.inst[30:25], ex_issue.inst[11:8], 1'b0};

    assign snpc     = ex_issue.pc + xlen_t'(INST_BYTES);
    assign jalr_sum = ex_issue.src_a + ex_issue.imm;

    // compare straight on the sources, no alu dependency
    assign eq  = ex_issue.src_a == ex_issue.src_b;
    assign lt  = $signed(ex_issue.src_a) < $signed(ex_issue.src_b);
    assign ltu = ex_issue.src_a < ex_issue.src_b;

    always_comb begin
        case (ex_issue.op)
            OP_BEQ:  taken = eq;
            OP_BNE:  taken = !eq;
            OP_BLT:  taken = lt;
            OP_BGE:  taken = !lt;
            OP_BLTU: taken = ltu;
            OP_BGEU: taken = !ltu;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        case (ex_issue.op)
            OP_JAL:            dnpc = ex_issue.pc + ex_issue.imm;
            OP_JALR:           dnpc = {jalr_sum[XLEN-1:1], 1'b0};
            // src_a carries mtvec for ecall, mepc for mret
            OP_ECALL, OP_MRET: dnpc = ex_issue.src_a;
            default:           dnpc = taken ? ex_issue.pc + b_off : snpc;
        endcase
    end

    // fetch redirect for every control op, taken or not
    assign pc_update = ex_issue.op inside {OP_JAL, OP_JALR, OP_BEQ, OP_BNE, OP_BLT,
                                           OP_BGE, OP_BLTU, OP_BGEU, OP_ECALL, OP_MRET};

endmodule

`default_nettype wire

//--- logic/exu_csr_write.sv
`timescale 1ns/10ps
`default_nettype none

module exu_csr_write (
    input  exu_data_pkg::ex_issue_t ex_issue,
    output exu_data_pkg::csr_wr_t   csr_wr
);
    import exu_op_pkg::*;
    import exu_data_pkg::*;

    csr_addr_e addr;
    xlen_t     wdata;
    logic      is_csr_op;

    // csr address sits in the i-type immediate field
    assign addr      = csr_addr_e'(ex_issue.inst[31:20]);
    assign is_csr_op = ex_issue.op inside {OP_CSRRW, OP_CSRRS};

    // csrrs sets bits on top of the old value in src_b
    assign wdata = (ex_issue.op == OP_CSRRS) ? (ex_issue.src_a | ex_issue.src_b)
                                             : ex_issue.src_a;

    always_comb begin
        csr_wr = '0;
        if (is_csr_op) begin
            case (addr)
                CSR_MTVEC: begin
                    csr_wr.wen_mtvec  = 1'b1;
                    csr_wr.data_mtvec = wdata;
                end
                CSR_MEPC: begin
                    csr_wr.wen_mepc  = 1'b1;
                    csr_wr.data_mepc = wdata;
                end
                CSR_MCAUSE: begin
                    csr_wr.wen_mcause  = 1'b1;
                    csr_wr.data_mcause = wdata;
                end
                CSR_MSTATUS: begin
                    csr_wr.wen_mstatus  = 1'b1;
                    csr_wr.data_mstatus = wdata;
                end
                // unknown address writes nothing
                default: csr_wr = '0;
            endcase
        end else if (ex_issue.op == OP_ECALL) begin
            // trap entry saves pc and cause together
            csr_wr.wen_mepc    = 1'b1;
            csr_wr.data_mepc   = ex_issue.pc;
            csr_wr.wen_mcause  = 1'b1;
            csr_wr.data_mcause = MCAUSE_ECALL_M;
        end
    end

endmodule

`default_nettype wire

//--- logic/exu_data_pkg.sv
`default_nettype none

package exu_data_pkg;

    // rv64 data and instruction widths
    parameter int XLEN       = 64;
    parameter int ILEN       = 32;
    // sequential pc step, no compressed instructions
    parameter int INST_BYTES = 4;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [ILEN-1:0] inst_t;

    // one issued instruction from decode
    typedef struct packed {
        exu_op_pkg::exu_op_e op;
        xlen_t               pc;
        inst_t               inst;
        xlen_t               src_a;
        // rs2 value, or old csr value for csr ops
        xlen_t               src_b;
        xlen_t               imm;
    } ex_issue_t;

    // payload towards the memory stage
    typedef struct packed {
        xlen_t pc;
        inst_t inst;
        xlen_t alu_result;
        xlen_t store_data;
    } ex_result_t;

    // csr write port, one strobe and one data word per csr
    typedef struct packed {
        logic  wen_mtvec;
        logic  wen_mepc;
        logic  wen_mcause;
        logic  wen_mstatus;
        xlen_t data_mtvec;
        xlen_t data_mepc;
        xlen_t data_mcause;
        xlen_t data_mstatus;
    } csr_wr_t;

endpackage

`default_nettype wire

//--- logic/exu_issue_reg.sv
`timescale 1ns/10ps
`default_nettype none

module exu_issue_reg (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    id_valid,
    input  exu_data_pkg::ex_issue_t id_issue,
    output logic                    ex_valid,
    output exu_data_pkg::ex_issue_t ex_issue
);
    import exu_op_pkg::*;
    import exu_data_pkg::*;

    logic      valid_q;
    ex_issue_t issue_q;

    // id/ex pipeline register, loads every cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q    <= 1'b0;
            issue_q    <= '0;
            issue_q.op <= OP_NOP;
        end else begin
            valid_q <= id_valid;
            issue_q <= id_issue;
        end
    end

    // bubble shows up as nop so downstream units stay idle
    always_comb begin
        ex_issue = issue_q;
        if (!valid_q) begin
            ex_issue.op = OP_NOP;
        end
    end

    assign ex_valid = valid_q;

endmodule

`default_nettype wire

//--- logic/exu_op_pkg.sv
`default_nettype none

package exu_op_pkg;

    // decoded opcode handed over by the decode stage
    // nop is zero so a cleared register reads as idle
    typedef enum logic [5:0] {
        OP_NOP = 6'd0,
        // register-register
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_SLTU,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        // register-immediate, imm carries shamt for shifts
        OP_ADDI,
        OP_ANDI,
        OP_ORI,
        OP_XORI,
        OP_SLLI,
        OP_SRLI,
        OP_SRAI,
        // 32-bit word forms, result sign-extended from bit 31
        OP_ADDW,
        OP_SUBW,
        OP_SLLW,
        OP_SRLW,
        OP_SRAW,
        // upper immediate and jumps
        OP_LUI,
        OP_AUIPC,
        OP_JAL,
        OP_JALR,
        // conditional branches
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_BLTU,
        OP_BGEU,
        // system
        OP_CSRRW,
        OP_CSRRS,
        OP_ECALL,
        OP_MRET
    } exu_op_e;

    // machine csr addresses handled here
    typedef enum logic [11:0] {
        CSR_MSTATUS = 12'h300,
        CSR_MTVEC   = 12'h305,
        CSR_MEPC    = 12'h341,
        CSR_MCAUSE  = 12'h342
    } csr_addr_e;

    // environment call from m-mode
    parameter logic [63:0] MCAUSE_ECALL_M = 64'd11;

endpackage

`default_nettype wire

//--- logic/exu_top.sv
`timescale 1ns/10ps
`default_nettype none

module exu_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     id_valid,
    input  exu_data_pkg::ex_issue_t  id_issue,
    output logic                     ex_valid,
    output exu_data_pkg::ex_result_t ex_result,
    output exu_data_pkg::xlen_t      dnpc,
    output logic                     pc_update,
    output exu_data_pkg::csr_wr_t    csr_wr
);
    import exu_data_pkg::*;

    ex_issue_t ex_issue;
    xlen_t     alu_result;

    exu_issue_reg u_issue_reg (
        .clk      (clk),
        .rst      (rst),
        .id_valid (id_valid),
        .id_issue (id_issue),
        .ex_valid (ex_valid),
        .ex_issue (ex_issue)
    );

    exu_alu u_alu (
        .ex_issue   (ex_issue),
        .alu_result (alu_result)
    );

    exu_branch_unit u_branch_unit (
        .ex_issue  (ex_issue),
        .dnpc      (dnpc),
        .pc_update (pc_update)
    );

    exu_csr_write u_csr_write (
        .ex_issue (ex_issue),
        .csr_wr   (csr_wr)
    );

    // store data is rs2 passed through unchanged
    assign ex_result = '{
        pc:         ex_issue.pc,
        inst:       ex_issue.inst,
        alu_result: alu_result,
        store_data: ex_issue.src_b
    };

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build the exu testbench with verilator and run it, result taken from sim.log
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module exu_tb -f exu.f -o exu_sim > build.log 2>&1 \
    && ./obj_dir/exu_sim +verilator+error+limit+1000 > sim.log 2>&1 \
    && ! grep -q "Simulation failed" sim.log \
    && echo "run passed, see sim.log" \
    || { echo "run failed, see build.log and sim.log"; exit 1; }

//--- verification/exu_assert.sv
`timescale 1ns/10ps
`default_nettype none

module exu_assert (
    input logic                    clk,
    input logic                    rst,
    input logic                    ex_valid,
    input logic                    pc_update,
    input exu_data_pkg::xlen_t     dnpc,
    input exu_data_pkg::csr_wr_t   csr_wr,
    input exu_data_pkg::ex_issue_t ex_issue
);
    import exu_op_pkg::*;
    import exu_data_pkg::*;

    // read back by the testbench at the end of the run
    int fail_count = 0;

    // a bubble must not redirect fetch or touch any csr
    idle_when_invalid: assert property (@(posedge clk) disable iff (rst)
        !ex_valid |-> !pc_update &&
            ({csr_wr.wen_mtvec, csr_wr.wen_mepc, csr_wr.wen_mcause, csr_wr.wen_mstatus} == 4'b0))
    else begin
        fail_count++;
        $error("pc_update or a csr enable is active without ex_valid");
    end

    // redirect target is always halfword aligned
    target_aligned: assert property (@(posedge clk) disable iff (rst)
        pc_update |-> !dnpc[0])
    else begin
        fail_count++;
        $error("dnpc bit 0 is set on a redirect");
    end

    // trap entry writes mepc and mcause as a pair
    ecall_pair: assert property (@(posedge clk) disable iff (rst)
        (ex_issue.op == OP_ECALL) |-> csr_wr.wen_mepc && (csr_wr.wen_mepc == csr_wr.wen_mcause))
    else begin
        fail_count++;
        $error("ecall did not raise mepc and mcause enables together");
    end

endmodule

`default_nettype wire

//--- verification/exu_tb.sv
`timescale 1ns/10ps
`default_nettype none

module exu_tb;
    import exu_op_pkg::*;
    import exu_data_pkg::*;

    localparam int CLK_HALF   = 20;
    localparam int RST_CYCLES = 16;
    localparam int N_RAND     = 40;

    localparam xlen_t PC0 = 64'h0000_0000_8000_0000;
    localparam xlen_t PC1 = 64'h0000_0000_8000_0100;
    localparam xlen_t M1  = 64'hFFFF_FFFF_FFFF_FFFF;
    localparam xlen_t M2  = 64'hFFFF_FFFF_FFFF_FFFE;
    // b-type encodings, offset +16 and offset -8
    localparam inst_t BP16 = 32'h0000_0863;
    localparam inst_t BM8  = 32'hFE00_0CE3;

    // expected response for one issued row
    typedef struct packed {
        xlen_t   alu;
        xlen_t   dnpc;
        logic    pc_update;
        csr_wr_t csr;
    } expect_t;

    logic        clk;
    logic        rst;
    logic        id_valid;
    ex_issue_t   id_issue;
    logic        ex_valid;
    ex_result_t  ex_result;
    xlen_t       dnpc;
    logic        pc_update;
    csr_wr_t     csr_wr;

    ex_issue_t   stim_q[$];
    expect_t     exp_q[$];
    int          n_table;
    int          errors;
    int          checks;
    int          assert_fails;
    logic [31:0] lcg_state;
    logic        built;

    exu_top u_exu_top (
        .clk       (clk),
        .rst       (rst),
        .id_valid  (id_valid),
        .id_issue  (id_issue),
        .ex_valid  (ex_valid),
        .ex_result (ex_result),
        .dnpc      (dnpc),
        .pc_update (pc_update),
        .csr_wr    (csr_wr)
    );

    bind exu_top exu_assert u_exu_assert (
        .clk       (clk),
        .rst       (rst),
        .ex_valid  (ex_valid),
        .pc_update (pc_update),
        .dnpc      (dnpc),
        .csr_wr    (csr_wr),
        .ex_issue  (ex_issue)
    );

    always #(CLK_HALF) clk = ~clk;

    // lcg step, state kept in lcg_state
    function automatic logic [31:0] rand32();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic xlen_t rand64();
        xlen_t v;
        v[63:32] = rand32();
        v[31:0]  = rand32();
        return v;
    endfunction

    // order mtvec, mepc, mcause, mstatus as in the struct
    function automatic logic [3:0] enables(input csr_wr_t c);
        return {c.wen_mtvec, c.wen_mepc, c.wen_mcause, c.wen_mstatus};
    endfunction

    // d goes to every enabled csr except mcause, which gets cause
    function automatic csr_wr_t expected_csr(input logic [3:0] wen, input xlen_t d,
                                             input xlen_t cause);
        csr_wr_t c;
        c = '0;
        {c.wen_mtvec, c.wen_mepc, c.wen_mcause, c.wen_mstatus} = wen;
        if (wen[3]) begin
            c.data_mtvec = d;
        end
        if (wen[2]) begin
            c.data_mepc = d;
        end
        if (wen[1]) begin
            c.data_mcause = cause;
        end
        if (wen[0]) begin
            c.data_mstatus = d;
        end
        return c;
    endfunction

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic add_row(input exu_op_e op, input xlen_t pc, input inst_t inst,
                           input xlen_t a, input xlen_t b, input xlen_t imm,
                           input xlen_t alu, input xlen_t npc, input logic pcu,
                           input csr_wr_t csr);
        ex_issue_t s;
        expect_t   e;
        s = '{op: op, pc: pc, inst: inst, src_a: a, src_b: b, imm: imm};
        e = '{alu: alu, dnpc: npc, pc_update: pcu, csr: csr};
        stim_q.push_back(s);
        exp_q.push_back(e);
    endtask

    // plain alu op, sequential next pc, no csr traffic
    task automatic add_alu(input exu_op_e op, input xlen_t a, input xlen_t b,
                           input xlen_t imm, input xlen_t res);
        add_row(op, PC0, 32'h0000_0013, a, b, imm, res, PC0 + 64'd4, 1'b0, '0);
    endtask

    task automatic add_branch(input exu_op_e op, input inst_t inst, input xlen_t a,
                              input xlen_t b, input xlen_t diff, input xlen_t npc);
        add_row(op, PC1, inst, a, b, 64'd0, diff, npc, 1'b1, '0);
    endtask

    task automatic add_csr(input exu_op_e op, input logic [11:0] addr, input xlen_t a,
                           input xlen_t b, input logic [3:0] wen, input xlen_t d);
        add_row(op, PC0, {addr, 20'h01073}, a, b, 64'd0, 64'd0, PC0 + 64'd4, 1'b0,
                expected_csr(wen, d, d));
    endtask

    task automatic build_table();
        // register ops
        add_alu(OP_ADD,  64'd5, 64'd7, 64'd0, 64'd12);
        add_alu(OP_SUB,  64'd3, 64'd5, 64'd0, M2);
        add_alu(OP_AND,  64'hF0F0, 64'hFF00, 64'd0, 64'hF000);
        add_alu(OP_OR,   64'hF0F0, 64'h0F0F, 64'd0, 64'hFFFF);
        add_alu(OP_XOR,  64'hFF00, 64'h0FF0, 64'd0, 64'hF0F0);
        add_alu(OP_SLT,  M1, 64'd1, 64'd0, 64'd1);
        add_alu(OP_SLTU, M1, 64'd1, 64'd0, 64'd0);
        add_alu(OP_SLL,  64'd1, 64'd63, 64'd0, 64'h8000_0000_0000_0000);
        add_alu(OP_SRL,  64'h8000_0000_0000_0000, 64'd63, 64'd0, 64'd1);
        // only the low 6 bits of 0x104 count
        add_alu(OP_SRA,  64'h8000_0000_0000_0000, 64'h104, 64'd0, 64'hF800_0000_0000_0000);
        // immediate ops
        add_alu(OP_ADDI, 64'd100, 64'd0, M1, 64'd99);
        add_alu(OP_ANDI, 64'hFF, 64'd0, 64'h0F, 64'h0F);
        add_alu(OP_ORI,  64'hF0, 64'd0, 64'h0F, 64'hFF);
        add_alu(OP_XORI, 64'hFF, 64'd0, M1, 64'hFFFF_FFFF_FFFF_FF00);
        add_alu(OP_SLLI, 64'd3, 64'd0, 64'd32, 64'h0000_0003_0000_0000);
        add_alu(OP_SRLI, M1, 64'd0, 64'd60, 64'hF);
        add_alu(OP_SRAI, 64'h8000_0000_0000_0000, 64'd0, 64'd63, M1);
        // word ops, 5-bit shamt and sign extension of bit 31
        add_alu(OP_ADDW, 64'h7FFF_FFFF, 64'd1, 64'd0, 64'hFFFF_FFFF_8000_0000);
        add_alu(OP_SUBW, 64'h1234_5678_0000_0000, 64'd1, 64'd0, M1);
        add_alu(OP_SLLW, 64'd1, 64'd63, 64'd0, 64'hFFFF_FFFF_8000_0000);
        add_alu(OP_SRLW, 64'hFFFF_FFFF_8000_0000, 64'd4, 64'd0, 64'h0800_0000);
        add_alu(OP_SRAW, 64'h8000_0000, 64'd4, 64'd0, 64'hFFFF_FFFF_F800_0000);
        add_alu(OP_LUI,  64'h55, 64'd0, 64'hFFFF_FFFF_ABCD_E000, 64'hFFFF_FFFF_ABCD_E000);
        add_alu(OP_AUIPC, 64'h55, 64'd0, 64'h1000, 64'h8000_1000);
        // jumps link pc+4, jalr clears bit 0 of an odd sum
        add_row(OP_JAL, PC0, 32'h1000_006F, 64'd0, 64'd0, 64'h100, 64'h8000_0004,
                64'h8000_0100, 1'b1, '0);
        add_row(OP_JAL, PC0, 32'hFF9F_F06F, 64'd0, 64'd0, 64'hFFFF_FFFF_FFFF_FFF8,
                64'h8000_0004, 64'h7FFF_FFF8, 1'b1, '0);
        add_row(OP_JALR, PC0, 32'h0100_0067, 64'h2001, 64'd0, 64'h10, 64'h8000_0004,
                64'h2010, 1'b1, '0);
        add_row(OP_JALR, PC0, 32'hFFC0_0067, 64'h3000, 64'd0, 64'hFFFF_FFFF_FFFF_FFFC,
                64'h8000_0004, 64'h2FFC, 1'b1, '0);
        // branches taken and not taken, signed vs unsigned with -1
        add_branch(OP_BEQ,  BP16, 64'd5, 64'd5, 64'd0, 64'h8000_0110);
        add_branch(OP_BEQ,  BP16, 64'd5, 64'd6, M1, 64'h8000_0104);
        add_branch(OP_BNE,  BM8,  64'd5, 64'd6, M1, 64'h8000_00F8);
        add_branch(OP_BNE,  BM8,  64'd7, 64'd7, 64'd0, 64'h8000_0104);
        add_branch(OP_BLT,  BP16, M1, 64'd1, M2, 64'h8000_0110);
        add_branch(OP_BLT,  BP16, 64'd1, M1, 64'd2, 64'h8000_0104);
        add_branch(OP_BGE,  BM8,  64'd1, M1, 64'd2, 64'h8000_00F8);
        add_branch(OP_BGE,  BM8,  M1, 64'd1, M2, 64'h8000_0104);
        add_branch(OP_BLTU, BP16, 64'd1, M1, 64'd2, 64'h8000_0110);
        add_branch(OP_BLTU, BP16, M1, 64'd1, M2, 64'h8000_0104);
        add_branch(OP_BGEU, BM8,  M1, 64'd1, M2, 64'h8000_00F8);
        add_branch(OP_BGEU, BM8,  64'd1, M1, 64'd2, 64'h8000_0104);
        // csr writes, src_b is the old value for csrrs
        add_csr(OP_CSRRW, 12'h305, 64'h8000_0400, 64'h123, 4'b1000, 64'h8000_0400);
        add_csr(OP_CSRRW, 12'h341, 64'h8000_1234, 64'h0, 4'b0100, 64'h8000_1234);
        add_csr(OP_CSRRW, 12'h342, 64'h7, 64'h0, 4'b0010, 64'h7);
        add_csr(OP_CSRRW, 12'h300, 64'h1888, 64'h0, 4'b0001, 64'h1888);
        add_csr(OP_CSRRS, 12'h305, 64'h3, 64'h8000_0400, 4'b1000, 64'h8000_0403);
        add_csr(OP_CSRRS, 12'h341, 64'h10, 64'h1, 4'b0100, 64'h11);
        add_csr(OP_CSRRS, 12'h342, 64'h8, 64'h3, 4'b0010, 64'hB);
        add_csr(OP_CSRRS, 12'h300, 64'h8, 64'h1800, 4'b0001, 64'h1808);
        // mie and mscratch are not handled here
        add_csr(OP_CSRRW, 12'h304, 64'h5, 64'h0, 4'b0000, 64'h0);
        add_csr(OP_CSRRS, 12'h340, 64'h5, 64'h1, 4'b0000, 64'h0);
        // ecall: mepc gets pc, mcause 11, jump to src_a
        add_row(OP_ECALL, PC0, 32'h0000_0073, 64'h8000_0400, 64'd0, 64'd0, 64'd0,
                64'h8000_0400, 1'b1, expected_csr(4'b0110, PC0, 64'd11));
        add_row(OP_MRET, PC0, 32'h3020_0073, 64'h8000_1234, 64'd0, 64'd0, 64'd0,
                64'h8000_1234, 1'b1, '0);
    endtask

    task automatic build_random();
        xlen_t       a;
        xlen_t       b;
        xlen_t       pc;
        xlen_t       res;
        exu_op_e     op;
        logic [31:0] sel;
        for (int k = 0; k < N_RAND; k++) begin
            a   = rand64();
            b   = rand64();
            sel = rand32() % 32'd3;
            pc  = PC0 + xlen_t'(4 * k);
            case (sel)
                32'd0: begin
                    op  = OP_ADD;
                    res = a + b;
                end
                32'd1: begin
                    op  = OP_SUB;
                    res = a - b;
                end
                default: begin
                    op  = OP_XOR;
                    res = a ^ b;
                end
            endcase
            add_row(op, pc, rand32(), a, b, 64'd0, res, pc + 64'd4, 1'b0, '0);
        end
    endtask

    task automatic check_idle();
        compare("ex_valid", 64'(ex_valid), 64'd0);
        compare("pc_update", 64'(pc_update), 64'd0);
        compare("csr_wen", 64'(enables(csr_wr)), 64'd0);
    endtask

    task automatic check_row(input int i);
        compare("ex_valid", 64'(ex_valid), 64'd1);
        compare("alu_result", ex_result.alu_result, exp_q[i].alu);
        compare("dnpc", dnpc, exp_q[i].dnpc);
        compare("pc_update", 64'(pc_update), 64'(exp_q[i].pc_update));
        compare("csr_wen", 64'(enables(csr_wr)), 64'(enables(exp_q[i].csr)));
        compare("data_mtvec", csr_wr.data_mtvec, exp_q[i].csr.data_mtvec);
        compare("data_mepc", csr_wr.data_mepc, exp_q[i].csr.data_mepc);
        compare("data_mcause", csr_wr.data_mcause, exp_q[i].csr.data_mcause);
        compare("data_mstatus", csr_wr.data_mstatus, exp_q[i].csr.data_mstatus);
        compare("ex_result.pc", ex_result.pc, stim_q[i].pc);
        compare("ex_result.inst", 64'(ex_result.inst), 64'(stim_q[i].inst));
        compare("store_data", ex_result.store_data, stim_q[i].src_b);
    endtask

    // one row per edge, row i-1 is visible at the negedge after row i is driven
    task automatic run_stream(input int first, input int last);
        for (int i = first; i <= last + 1; i++) begin
            @(posedge clk);
            if (i <= last) begin
                id_valid <= 1'b1;
                id_issue <= stim_q[i];
            end else begin
                id_valid <= 1'b0;
            end
            @(negedge clk);
            if (i > first) begin
                check_row(i - 1);
            end
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        id_valid  = 1'b0;
        id_issue  = '0;
        errors    = 0;
        checks    = 0;
        built     = 1'b0;
        lcg_state = 32'hef06_da95;
        build_table();
        n_table = stim_q.size();
        build_random();
        built = 1'b1;
        // reset, release on the last of the 16 edges
        for (int c = 0; c < RST_CYCLES; c++) begin
            @(posedge clk);
            if (c == RST_CYCLES - 1) begin
                rst <= 1'b0;
            end
            @(negedge clk);
            check_idle();
        end
        // cleared register gives an all-zero payload
        compare("ex_result.alu_result", ex_result.alu_result, 64'd0);
        compare("ex_result.pc", ex_result.pc, 64'd0);
        compare("ex_result.inst", 64'(ex_result.inst), 64'd0);
        compare("store_data", ex_result.store_data, 64'd0);
        // first cycle out of reset with id_valid low
        @(posedge clk);
        @(negedge clk);
        check_idle();
        run_stream(0, n_table - 1);
        @(posedge clk);
        @(negedge clk);
        check_idle();
        // back-to-back random stream
        run_stream(n_table, stim_q.size() - 1);
        @(posedge clk);
        @(negedge clk);
        check_idle();
        assert_fails = u_exu_top.u_exu_assert.fail_count;
        $display("checks %0d, value mismatches %0d, assertion failures %0d",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // limit from the number of rows plus reset and some slack
    initial begin
        wait (built);
        #((stim_q.size() + RST_CYCLES + 10) * 2 * CLK_HALF);
        $display("watchdog expired before all rows were checked");
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire
